// File: filelist.f
logic/dataPathPkg.sv
logic/regFile.sv
logic/aluCore.sv
logic/shiftUnit.sv
logic/resultSelect.sv
logic/dataPath.sv
tests/dataPath_assert.sv
tests/dataPathTb.sv

// File: Makefile
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP ?= dataPathTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/dataPathTb.sv
`default_nettype none

module dataPathTb import dataPathPkg::*; ();

	localparam int PlannedOps = 2000;
	localparam int CycleLimit = 2 * PlannedOps;
	localparam int ResetCycles = 4;

	logic CLK;
	logic rstN;
	logic selectImm;
	logic [RegAddrWidth-1:0] readRegA;
	logic [RegAddrWidth-1:0] readRegB;
	logic [LoadRegWidth-1:0] loadReg;
	logic [ImmWidth-1:0] imm;
	aluOpE op;
	logic [DataWidth-1:0] a;
	logic [DataWidth-1:0] b;
	logic [DataWidth-1:0] z;
	logic [FlagCount-1:0] flags;

	// Reference state
	logic [DataWidth-1:0] modelRegs [RegCount];
	logic [FlagCount-1:0] modelFlags;

	int seed = 32'h51db871d;
	int errorCount = 0;
	int cycleCount = 0;

	dataPath u_dataPath (
		.CLK(CLK),
		.rstN(rstN),
		.selectImm(selectImm),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.loadReg(loadReg),
		.imm(imm),
		.op(op),
		.a(a),
		.b(b),
		.z(z),
		.flags(flags)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Watchdog
	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", CycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	function automatic logic [7:0] validOpAt(int idx);
		case (idx)
			0: return OpAdd;
			1: return OpAddc;
			2: return OpSub;
			3: return OpCmp;
			4: return OpAnd;
			5: return OpOr;
			6: return OpXor;
			7: return OpMov;
			8: return OpLsh;
			default: return OpAshu;
		endcase
	endfunction

	function automatic logic isValidCode(logic [7:0] code);
		for (int i = 0; i < 10; i++) begin
			if (validOpAt(i) == code) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic compareValue(string name, logic [DataWidth-1:0] expected,
		logic [DataWidth-1:0] actual);
		assert (expected == actual) else begin
			errorCount++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Expected result, flags and validity from the datapath rules
	task automatic computeModel(input logic [7:0] code, input logic [DataWidth-1:0] opA,
		input logic [DataWidth-1:0] opB, input logic carryIn,
		output logic [DataWidth-1:0] expZ, output logic [FlagCount-1:0] expFlags,
		output logic valid);
		int ua;
		int ub;
		int sa;
		int sb;
		int sum;
		int amt;
		logic [DataWidth-1:0] r;
		logic c;
		ua = int'(opA);
		ub = int'(opB);
		sa = int'($signed(opA));
		sb = int'($signed(opB));
		expZ = '0;
		expFlags = '0;
		valid = 1'b1;
		case (code)
			OpAdd, OpAddc: begin
				c = (code == OpAddc) ? carryIn : 1'b0;
				sum = ua + ub + int'(c);
				expZ = sum[DataWidth-1:0];
				expFlags[FlagC] = (sum > 65535);
				sum = sa + sb + int'(c);
				expFlags[FlagF] = (sum > 32767) || (sum < -32768);
			end
			OpSub: begin
				sum = ua - ub;
				expZ = sum[DataWidth-1:0];
				expFlags[FlagC] = (ua < ub);
				sum = sa - sb;
				expFlags[FlagF] = (sum > 32767) || (sum < -32768);
			end
			OpCmp: begin
				expFlags[FlagZ] = (ua == ub);
				expFlags[FlagL] = (ua < ub);
				expFlags[FlagN] = (sa < sb);
			end
			OpAnd, OpOr, OpXor, OpMov: begin
				case (code)
					OpAnd: expZ = opA & opB;
					OpOr: expZ = opA | opB;
					OpXor: expZ = opA ^ opB;
					default: expZ = opB;
				endcase
				expFlags[FlagZ] = (expZ == '0);
				expFlags[FlagN] = expZ[DataWidth-1];
			end
			OpLsh, OpAshu: begin
				// One bit at a time so C keeps the last bit shifted out
				amt = int'($signed(opB[ShiftAmtWidth-1:0]));
				r = opA;
				c = 1'b0;
				for (int k = 0; k < amt; k++) begin
					c = r[DataWidth-1];
					r = {r[DataWidth-2:0], 1'b0};
				end
				for (int k = 0; k < -amt; k++) begin
					c = r[0];
					r = {(code == OpAshu) ? r[DataWidth-1] : 1'b0, r[DataWidth-1:1]};
				end
				expZ = r;
				expFlags[FlagC] = c;
				expFlags[FlagZ] = (r == '0);
				expFlags[FlagN] = r[DataWidth-1];
			end
			default: valid = 1'b0;
		endcase
	endtask

	// One operation driven, checked before the edge and flag-checked after it
	task automatic runOp(input logic selImm, input logic [RegAddrWidth-1:0] ra,
		input logic [RegAddrWidth-1:0] rb, input logic [LoadRegWidth-1:0] ld,
		input logic [ImmWidth-1:0] immVal, input logic [7:0] code);
		int immSigned;
		logic [DataWidth-1:0] expA;
		logic [DataWidth-1:0] expB;
		logic [DataWidth-1:0] expZ;
		logic [FlagCount-1:0] expFlags;
		logic valid;
		selectImm = selImm;
		readRegA = ra;
		readRegB = rb;
		loadReg = ld;
		imm = immVal;
		op = aluOpE'(code);
		expA = modelRegs[ra];
		immSigned = int'($signed(immVal));
		expB = selImm ? immSigned[DataWidth-1:0] : modelRegs[rb];
		computeModel(code, expA, expB, modelFlags[FlagC], expZ, expFlags, valid);
		#6;
		compareValue("a", expA, a);
		compareValue("b", expB, b);
		compareValue("z", expZ, z);
		if (valid && code != OpCmp && ld < 5'd16) begin
			modelRegs[ld[RegAddrWidth-1:0]] = expZ;
		end
		if (valid) begin
			modelFlags = expFlags;
		end
		@(posedge CLK);
		#1;
		compareValue("flags", {{(DataWidth-FlagCount){1'b0}}, modelFlags},
			{{(DataWidth-FlagCount){1'b0}}, flags});
	endtask

	////////////////////////////////////////
	// Test phases
	////////////////////////////////////////

	// Invalid code with no target leaves every register unchanged
	task automatic readAllRegs();
		for (int i = 0; i < RegCount; i++) begin
			runOp(1'b0, 4'(i), 4'(RegCount - 1 - i), 5'd31, 8'h00, 8'h00);
		end
	endtask

	task automatic runRandomOps(int count, logic immOnly);
		logic [31:0] rnd;
		logic selImm;
		for (int i = 0; i < count; i++) begin
			rnd = nextRandom();
			selImm = immOnly || (rnd[21:20] == 2'b00);
			runOp(selImm, rnd[3:0], rnd[7:4], {1'b0, rnd[11:8]}, rnd[19:12],
				validOpAt(int'(rnd[25:22]) % 10));
		end
	endtask

	// Add then two add-with-carry steps riding on the stored C
	task automatic runCarryChains(int count);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = nextRandom();
			runOp(1'b0, rnd[3:0], rnd[7:4], {1'b0, rnd[11:8]}, 8'h00, OpAdd);
			runOp(rnd[12], rnd[15:12], rnd[19:16], {1'b0, rnd[23:20]}, rnd[31:24], OpAddc);
			runOp(1'b0, rnd[19:16], rnd[3:0], {1'b0, rnd[27:24]}, 8'h00, OpAddc);
		end
	endtask

	task automatic runCompares(int count);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = nextRandom();
			runOp(rnd[20], rnd[3:0], rnd[7:4], {1'b0, rnd[11:8]}, rnd[19:12], OpCmp);
		end
	endtask

	task automatic runShifts(int count);
		logic [31:0] rnd;
		logic [ImmWidth-1:0] amt;
		logic [7:0] code;
		for (int i = 0; i < count; i++) begin
			rnd = nextRandom();
			amt = rnd[19:12];
			// Every fifth shift uses a zero amount
			if (i % 5 == 0) begin
				amt[ShiftAmtWidth-1:0] = '0;
			end
			code = rnd[24] ? OpAshu : OpLsh;
			runOp(rnd[25] || (i % 5 == 0), rnd[3:0], rnd[7:4], {1'b0, rnd[11:8]}, amt, code);
		end
	endtask

	task automatic runInvalidOps(int count);
		logic [31:0] rnd;
		logic [7:0] code;
		for (int i = 0; i < count; i++) begin
			rnd = nextRandom();
			code = rnd[31:24];
			while (isValidCode(code)) begin
				code = code + 8'd1;
			end
			runOp(rnd[20], rnd[3:0], rnd[7:4], rnd[12:8], rnd[19:12], code);
		end
	endtask

	// Valid ops aimed at loadReg 16 to 31
	task automatic runNoTargetWrites(int count);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = nextRandom();
			runOp(rnd[20], rnd[3:0], rnd[7:4], {1'b1, rnd[11:8]}, rnd[19:12],
				validOpAt(int'(rnd[25:22]) % 10));
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int assertFails;
		rstN = 1'b0;
		selectImm = 1'b0;
		readRegA = '0;
		readRegB = '0;
		loadReg = 5'd31;
		imm = '0;
		op = aluOpE'(8'h00);
		for (int i = 0; i < RegCount; i++) begin
			modelRegs[i] = '0;
		end
		modelFlags = '0;

		repeat (ResetCycles) @(posedge CLK);
		#1;
		rstN = 1'b1;
		compareValue("flags", '0, {{(DataWidth-FlagCount){1'b0}}, flags});

		readAllRegs();

		// Seed every register through move immediate
		for (int i = 0; i < RegCount; i++) begin
			runOp(1'b1, 4'd0, 4'd0, 5'(i), nextRandom() & 8'hff, OpMov);
		end

		runRandomOps(1300, 1'b0);
		runRandomOps(200, 1'b1);
		runCarryChains(50);
		runCompares(50);
		runShifts(150);
		runInvalidOps(60);
		runNoTargetWrites(40);
		readAllRegs();

		assertFails = u_dataPath.u_dataPathAssert.failCount;
		$display("Run finished: %0d check errors, %0d assertion failures",
			errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/dataPath_assert.sv
`default_nettype none

module dataPathAssert import dataPathPkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic opValid,
	input wire logic [DataWidth-1:0] z,
	input wire logic [FlagCount-1:0] flags
);

	int failCount = 0;

	// Flag register is clear one edge after reset
	resetClearsFlags: assert property (@(posedge CLK) !rstN |=> flags == '0)
		else begin
			failCount++;
			$error("flags not cleared after reset");
		end

	// Invalid op leaves the flags alone
	invalidHoldsFlags: assert property (@(posedge CLK) disable iff (!rstN)
		!opValid |=> $stable(flags))
		else begin
			failCount++;
			$error("flags changed on an invalid opcode");
		end

	invalidZeroResult: assert property (@(posedge CLK) !opValid |-> z == '0)
		else begin
			failCount++;
			$error("z nonzero with invalid opcode");
		end

endmodule

bind dataPath dataPathAssert u_dataPathAssert (
	.CLK(CLK),
	.rstN(rstN),
	.opValid(opValid),
	.z(z),
	.flags(flags)
);

`default_nettype wire

// File: logic/dataPath.sv
`default_nettype none

module dataPath import dataPathPkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic selectImm,
	input wire logic [RegAddrWidth-1:0] readRegA,
	input wire logic [RegAddrWidth-1:0] readRegB,
	input wire logic [LoadRegWidth-1:0] loadReg,
	input wire logic [ImmWidth-1:0] imm,
	input wire aluOpE op,
	output logic [DataWidth-1:0] a,
	output logic [DataWidth-1:0] b,
	output logic [DataWidth-1:0] z,
	output logic [FlagCount-1:0] flags
);

	logic [DataWidth-1:0] regB;
	logic [DataWidth-1:0] immExt;
	logic [DataWidth-1:0] aluResult;
	logic [FlagCount-1:0] aluFlags;
	logic [DataWidth-1:0] shiftResult;
	logic [FlagCount-1:0] shiftFlags;
	logic opValid;
	logic writeEn;
	logic carry;

	regFile u_regFile (
		.CLK(CLK),
		.rstN(rstN),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.loadReg(loadReg),
		.writeEn(writeEn),
		.writeData(z),
		.regA(a),
		.regB(regB)
	);

	// Operand B is either read port B or the sign-extended immediate
	assign immExt = {{(DataWidth-ImmWidth){imm[ImmWidth-1]}}, imm};
	assign b = selectImm ? immExt : regB;

	////////////////////////////////////////
	// Execute units and writeback select
	////////////////////////////////////////

	aluCore u_aluCore (
		.a(a),
		.b(b),
		.op(op),
		.carryIn(carry),
		.result(aluResult),
		.flags(aluFlags)
	);

	shiftUnit u_shiftUnit (
		.a(a),
		.b(b),
		.op(op),
		.result(shiftResult),
		.flags(shiftFlags)
	);

	resultSelect u_resultSelect (
		.CLK(CLK),
		.rstN(rstN),
		.op(op),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.shiftResult(shiftResult),
		.shiftFlags(shiftFlags),
		.result(z),
		.opValid(opValid),
		.writeEn(writeEn),
		.carry(carry),
		.flags(flags)
	);

endmodule

`default_nettype wire

// File: logic/resultSelect.sv
`default_nettype none

module resultSelect import dataPathPkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire aluOpE op,
	input wire logic [DataWidth-1:0] aluResult,
	input wire logic [FlagCount-1:0] aluFlags,
	input wire logic [DataWidth-1:0] shiftResult,
	input wire logic [FlagCount-1:0] shiftFlags,
	output logic [DataWidth-1:0] result,
	output logic opValid,
	output logic writeEn,
	output logic carry,
	output logic [FlagCount-1:0] flags
);

	logic [FlagCount-1:0] nextFlags;
	logic [FlagCount-1:0] flagReg;

	////////////////////////////////////////
	// Opcode class and result routing
	////////////////////////////////////////

	always_comb begin
		result = '0;
		nextFlags = '0;
		opValid = 1'b0;

		case (op)
			OpAdd, OpAddc, OpSub, OpCmp, OpAnd, OpOr, OpXor, OpMov: begin
				result = aluResult;
				nextFlags = aluFlags;
				opValid = 1'b1;
			end
			OpLsh, OpAshu: begin
				result = shiftResult;
				nextFlags = shiftFlags;
				opValid = 1'b1;
			end
			// Invalid code, z stays zero
			default: opValid = 1'b0;
		endcase
	end

	// Compare updates flags but never a register
	assign writeEn = opValid && (op != OpCmp);

	// Flags hold across invalid operations
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			flagReg <= '0;
		end else if (opValid) begin
			flagReg <= nextFlags;
		end
	end

	assign flags = flagReg;
	assign carry = flagReg[FlagC];

endmodule

`default_nettype wire

// File: logic/shiftUnit.sv
`default_nettype none

module shiftUnit import dataPathPkg::*; (
	input wire logic [DataWidth-1:0] a,
	input wire logic [DataWidth-1:0] b,
	input wire aluOpE op,
	output logic [DataWidth-1:0] result,
	output logic [FlagCount-1:0] flags
);

	logic signed [ShiftAmtWidth-1:0] amount;
	logic [ShiftAmtWidth-1:0] rightAmt;
	logic [2*DataWidth-1:0] leftWide;
	logic [2*DataWidth-1:0] rightWide;
	logic carry;

	// Positive amount shifts left, negative shifts right
	assign amount = b[ShiftAmtWidth-1:0];

	// Magnitude of a right shift, 1 to 16
	assign rightAmt = -amount;

	// Double-width shifts keep the last bit shifted out next to the result
	assign leftWide = {{DataWidth{1'b0}}, a} << unsigned'(amount);

	always_comb begin
		if (op == OpAshu) begin
			rightWide = $signed({a, {DataWidth{1'b0}}}) >>> rightAmt;
		end else begin
			rightWide = {a, {DataWidth{1'b0}}} >> rightAmt;
		end
	end

	always_comb begin
		if (amount == '0) begin
			result = a;
			carry = 1'b0;
		end else if (!amount[ShiftAmtWidth-1]) begin
			result = leftWide[DataWidth-1:0];
			carry = leftWide[DataWidth];
		end else begin
			result = rightWide[2*DataWidth-1:DataWidth];
			carry = rightWide[DataWidth-1];
		end

		flags = '0;
		flags[FlagC] = carry;
		flags[FlagZ] = (result == '0);
		flags[FlagN] = result[DataWidth-1];
	end

endmodule

`default_nettype wire

// File: logic/aluCore.sv
`default_nettype none

module aluCore import dataPathPkg::*; (
	input wire logic [DataWidth-1:0] a,
	input wire logic [DataWidth-1:0] b,
	input wire aluOpE op,
	input wire logic carryIn,
	output logic [DataWidth-1:0] result,
	output logic [FlagCount-1:0] flags
);

	logic carryAdd;
	logic [DataWidth:0] sumWide;
	logic [DataWidth:0] diffWide;
	logic sumOverflow;
	logic diffOverflow;
	logic signedLess;
	logic isLogic;

	////////////////////////////////////////
	// Shared adder and subtractor
	////////////////////////////////////////

	// Stored carry only enters the sum for add-with-carry
	assign carryAdd = (op == OpAddc) && carryIn;

	assign sumWide = {1'b0, a} + {1'b0, b} + {{DataWidth{1'b0}}, carryAdd};

	// Top bit of the difference is the unsigned borrow
	assign diffWide = {1'b0, a} - {1'b0, b};

	// Same-sign operands giving a result of the other sign
	assign sumOverflow = (a[DataWidth-1] == b[DataWidth-1])
		&& (sumWide[DataWidth-1] != a[DataWidth-1]);

	assign diffOverflow = (a[DataWidth-1] != b[DataWidth-1])
		&& (diffWide[DataWidth-1] != a[DataWidth-1]);

	assign signedLess = $signed(a) < $signed(b);

	////////////////////////////////////////
	// Operation select and flags
	////////////////////////////////////////

	always_comb begin
		result = '0;
		flags = '0;
		isLogic = 1'b0;

		case (op)
			OpAdd, OpAddc: begin
				result = sumWide[DataWidth-1:0];
				flags[FlagC] = sumWide[DataWidth];
				flags[FlagF] = sumOverflow;
			end
			OpSub: begin
				result = diffWide[DataWidth-1:0];
				flags[FlagC] = diffWide[DataWidth];
				flags[FlagF] = diffOverflow;
			end
			// Compare only sets flags, result stays zero
			OpCmp: begin
				flags[FlagZ] = (a == b);
				flags[FlagL] = diffWide[DataWidth];
				flags[FlagN] = signedLess;
			end
			OpAnd: begin
				result = a & b;
				isLogic = 1'b1;
			end
			OpOr: begin
				result = a | b;
				isLogic = 1'b1;
			end
			OpXor: begin
				result = a ^ b;
				isLogic = 1'b1;
			end
			OpMov: begin
				result = b;
				isLogic = 1'b1;
			end
			default: begin
				result = '0;
			end
		endcase

		// Logic ops and move report zero and sign of the result
		if (isLogic) begin
			flags[FlagZ] = (result == '0);
			flags[FlagN] = result[DataWidth-1];
		end
	end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none

module regFile import dataPathPkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic [RegAddrWidth-1:0] readRegA,
	input wire logic [RegAddrWidth-1:0] readRegB,
	input wire logic [LoadRegWidth-1:0] loadReg,
	input wire logic writeEn,
	input wire logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] regA,
	output logic [DataWidth-1:0] regB
);

	logic [DataWidth-1:0] regs [RegCount];
	logic writeHit;
	logic [RegAddrWidth-1:0] writeAddr;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	// Upper half of the loadReg range is a no-write code
	assign writeHit = writeEn && (loadReg < LoadRegWidth'(RegCount));
	assign writeAddr = loadReg[RegAddrWidth-1:0];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeHit) begin
			regs[writeAddr] <= writeData;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Plain array reads, new data visible the cycle after the write
	assign regA = regs[readRegA];
	assign regB = regs[readRegB];

endmodule

`default_nettype wire

// File: logic/dataPathPkg.sv
`default_nettype none

package dataPathPkg;

	////////////////////////////////////////
	// Word and register file sizes
	////////////////////////////////////////

	localparam int DataWidth = 16;
	localparam int RegCount = 16;
	localparam int RegAddrWidth = 4;

	// One extra bit so that codes 16 to 31 select no register
	localparam int LoadRegWidth = 5;

	localparam int ImmWidth = 8;

	// Shift amount is a signed field in the low bits of B
	localparam int ShiftAmtWidth = 5;

	////////////////////////////////////////
	// Flag register layout
	////////////////////////////////////////

	localparam int FlagCount = 5;
	localparam int FlagC = 4;
	localparam int FlagL = 3;
	localparam int FlagF = 2;
	localparam int FlagZ = 1;
	localparam int FlagN = 0;

	// Opcodes; any code not listed here is invalid
	typedef enum logic [7:0] {
		OpAnd  = 8'h01,
		OpOr   = 8'h02,
		OpXor  = 8'h03,
		OpAdd  = 8'h05,
		OpAddc = 8'h07,
		OpSub  = 8'h09,
		OpCmp  = 8'h0b,
		OpMov  = 8'h0d,
		OpLsh  = 8'h84,
		OpAshu = 8'h86
	} aluOpE;

endpackage

`default_nettype wire
